//--- vlog.f
+incdir+include
rtl/pack_pkg.sv
rtl/four_phase_if.sv
rtl/word_dispatcher.sv
rtl/word_lane.sv
rtl/lane_collector.sv
rtl/line_packer.sv
rtl/pack_top.sv
verif/tb_pack_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_pack_top \
  -Mdir obj_dir \
  -o sim_pack_top

./obj_dir/sim_pack_top 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi

echo "PASS"

//--- verif/tb_pack_top.sv
`include "pack_defines.svh"

module tb_pack_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_STREAMS  = 8;
  localparam int MAX_LEN      = 64;
  localparam int CYC_PER_WORD = 60;  // Loose bound with random stalls
  localparam int STREAM_CYC   = 200; // Reset, drain and idle tail
  localparam longint TIMEOUT_NS =
    longint'(NUM_STREAMS) * (MAX_LEN * CYC_PER_WORD + STREAM_CYC) * CLK_PERIOD;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  logic [`PACK_WORD_W-1:0] in_word;
  logic                    in_last;
  logic                    in_ready;
  pack_pkg::op_e           op;
  logic [`PACK_WORD_W-1:0] key;
  logic                    start;
  logic                    wr_available;
  logic                    wr_en;
  logic [`PACK_LINE_W-1:0] wr_data;
  logic                    done;

  logic [31:0]             lfsr;
  logic [`PACK_WORD_W-1:0] word_buf [$];  // Transformed words not yet in a line
  logic [`PACK_LINE_W-1:0] exp_lines [$];
  logic [`PACK_LINE_W-1:0] line_exp;

  pack_top u_pack_top (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_word      (in_word),
    .in_last      (in_last),
    .in_ready     (in_ready),
    .op           (op),
    .key          (key),
    .start        (start),
    .wr_available (wr_available),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .done         (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [`PACK_WORD_W-1:0] model_xform(input pack_pkg::op_e o,
      input logic [`PACK_WORD_W-1:0] k, input logic [`PACK_WORD_W-1:0] w);
    case (o)
      pack_pkg::OP_INVERT:  return ~w;
      pack_pkg::OP_XOR_KEY: return w ^ k;
      pack_pkg::OP_SWAP:    return {w[7:0], w[15:8], w[23:16], w[31:24]};
      default:              return w;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [`PACK_LINE_W-1:0] got,
                             input logic [`PACK_LINE_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %0h, expected %0h", name, got, exp));
    end
  endtask

  // First word lowest with zero words padding a short line
  task automatic model_line();
    logic [`PACK_LINE_W-1:0] line;
    line = '0;
    for (int i = 0; i < `PACK_WORDS_PER_LINE; i++) begin
      if (word_buf.size() != 0) begin
        line[i*`PACK_WORD_W +: `PACK_WORD_W] = word_buf.pop_front();
      end
    end
    exp_lines.push_back(line);
  endtask

  task automatic model_word(input logic [`PACK_WORD_W-1:0] w);
    word_buf.push_back(model_xform(op, key, w));
    if (word_buf.size() == `PACK_WORDS_PER_LINE) begin
      model_line();
    end
  endtask

  task automatic drive_flow(input logic stall);
    logic [31:0] r;
    if (stall) begin
      rand_bits(2, r);
      start <= (r[1:0] != 2'b00);
      rand_bits(1, r);
      wr_available <= r[0];
    end else begin
      start        <= 1'b1;
      wr_available <= 1'b1;
    end
  endtask

  task automatic send_words(input int len, input logic stall);
    logic [31:0] r;
    int          sent;
    logic        pend;
    sent = 0;
    pend = 1'b0;
    while (sent < len) begin
      @(posedge clk);
      drive_flow(stall);
      if (!pend) begin
        rand_bits(2, r);
        if (r[1:0] != 2'b00) begin
          rand_bits(32, r);
          in_word  <= r;
          in_last  <= (sent == len - 1);
          in_valid <= 1'b1;
          pend = 1'b1;
        end else begin
          in_valid <= 1'b0;
        end
      end
      @(negedge clk);
      check_value("done", 512'(done), 512'(0));
      if (pend && in_ready) begin // Taken on the coming edge
        model_word(in_word);
        sent++;
        pend = 1'b0;
      end
    end
    if (word_buf.size() != 0) begin
      model_line();
    end
    @(posedge clk);
    drive_flow(stall);
    in_valid <= 1'b0;
    in_last  <= 1'b0;
  endtask

  task automatic run_stream(input int idx);
    logic [31:0] r;
    logic [31:0] k;
    int          len;
    logic        stall;
    logic        seen;
    stall = (idx >= 2);
    rand_bits(2, r);
    rand_bits(32, k);
    if (idx == 0) begin
      len = 32;
    end else if (idx == 1) begin
      len = 21;
    end else if (idx == 4) begin
      len = 48;
    end else begin
      rand_bits(6, r);
      len = int'(r[5:0]) + 1;
      rand_bits(2, r);
    end
    @(posedge clk);
    rst          <= 1'b1;
    in_valid     <= 1'b0;
    in_last      <= 1'b0;
    op           <= (idx < 4) ? pack_pkg::op_e'(idx[1:0]) : pack_pkg::op_e'(r[1:0]);
    key          <= k;
    start        <= 1'b1;
    wr_available <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("in_ready", 512'(in_ready), 512'(0));
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("wr_en", 512'(wr_en), 512'(0));
    check_value("done", 512'(done), 512'(0));
    send_words(len, stall);
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk);
      drive_flow(stall);
      @(negedge clk);
      seen = done;
    end
    repeat (20) begin // A late write trips the monitor
      @(posedge clk);
      drive_flow(stall);
    end
    @(negedge clk);
    check_value("done", 512'(done), 512'(1));
  endtask

  // Line writes against the model
  always @(negedge clk) begin
    if (!rst) begin
      if (wr_en) begin
        if (exp_lines.size() == 0) begin
          abort_run("Line write seen with no line expected from the model");
        end else begin
          line_exp = exp_lines.pop_front();
          check_value("wr_data", wr_data, line_exp);
        end
      end
      if (done && exp_lines.size() != 0) begin
        abort_run("done rose before every expected line was written");
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run("Timeout: the streams did not finish in the expected time");
  end

  initial begin
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_word      = '0;
    in_last      = 1'b0;
    op           = pack_pkg::OP_PASS;
    key          = '0;
    start        = 1'b0;
    wr_available = 1'b0;
    lfsr         = 32'h4c4d_43c1;
    for (int s = 0; s < NUM_STREAMS; s++) begin
      run_stream(s);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- rtl/pack_top.sv
`include "pack_defines.svh"

module pack_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic [`PACK_WORD_W-1:0] in_word,
  input  logic                    in_last,
  output logic                    in_ready,
  input  pack_pkg::op_e           op,
  input  logic [`PACK_WORD_W-1:0] key,
  input  logic                    start,
  input  logic                    wr_available,
  output logic                    wr_en,
  output logic [`PACK_LINE_W-1:0] wr_data,
  output logic                    done
);

  four_phase_if disp_ch [`PACK_LANES] (); // Dispatcher to lanes
  four_phase_if lane_ch [`PACK_LANES] (); // Lanes to collector

  logic                   coll_req;
  logic                   coll_ack;
  pack_pkg::tagged_word_t coll_data;

  word_dispatcher u_dispatcher (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_last  (in_last),
    .in_word  (in_word),
    .in_ready (in_ready),
    .lanes    (disp_ch)
  );

  genvar g;
  generate
    for (g = 0; g < `PACK_LANES; g++) begin : g_lane
      word_lane u_lane (
        .clk  (clk),
        .rst  (rst),
        .op   (op),
        .key  (key),
        .up   (disp_ch[g]),
        .down (lane_ch[g])
      );
    end
  endgenerate

  lane_collector u_collector (
    .clk      (clk),
    .rst      (rst),
    .lanes    (lane_ch),
    .out_req  (coll_req),
    .out_ack  (coll_ack),
    .out_data (coll_data)
  );

  line_packer u_packer (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .wr_available (wr_available),
    .req          (coll_req),
    .ack          (coll_ack),
    .din          (coll_data),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .done         (done)
  );

endmodule

//--- rtl/line_packer.sv
`include "pack_defines.svh"

module line_packer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic                    wr_available,
  input  logic                    req,
  output logic                    ack,
  input  pack_pkg::tagged_word_t  din,
  output logic                    wr_en,
  output logic [`PACK_LINE_W-1:0] wr_data,
  output logic                    done
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } state_e;

  state_e                  state;
  logic [`PACK_CNT_W-1:0]  cnt;   // Words already in the shift register
  logic [`PACK_LINE_W-1:0] shift; // Newest word at the top
  logic [`PACK_LINE_W-1:0] shift_in;
  logic                    line_full;

  assign shift_in  = {din.payload, shift[`PACK_LINE_W-1:`PACK_WORD_W]};
  assign line_full = (cnt == `PACK_CNT_W'(`PACK_WORDS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
      ack   <= 1'b0;
      wr_en <= 1'b0;
      done  <= 1'b0;
    end else begin
      wr_en <= 1'b0; // Single-cycle write strobe
      if (start && wr_available) begin
        case (state)
          IDLE: begin
            if (req) begin
              ack   <= 1'b1;
              state <= WAIT;
              case (din.tag)
                pack_pkg::TAG_DATA: begin
                  if (line_full) begin
                    cnt   <= '0;
                    wr_en <= 1'b1;
                  end else begin
                    cnt <= cnt + 1'b1;
                  end
                end
                pack_pkg::TAG_END: begin
                  if (cnt != '0) begin
                    wr_en <= 1'b1; // Flush the partial line
                  end
                  cnt   <= '0;
                  state <= DONE;
                end
                default: ;
              endcase
            end
          end
          WAIT: begin
            if (!req) begin
              ack   <= 1'b0;
              state <= IDLE;
            end
          end
          DONE: begin
            if (!req) begin
              ack <= 1'b0;
            end
            done <= 1'b1; // Held until reset
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (start && wr_available && state == IDLE && req) begin
      if (din.tag == pack_pkg::TAG_DATA) begin
        shift <= shift_in;
        if (line_full) begin
          wr_data <= shift_in;
        end
      end else if (din.tag == pack_pkg::TAG_END) begin
        // Drop the stale low slots, zeros fill the top
        wr_data <= shift >> (`PACK_WORD_W * (`PACK_WORDS_PER_LINE - int'(cnt)));
      end
    end
  end

  a_wr_pulse: assert property (@(posedge clk) disable iff (rst) wr_en |=> !wr_en);

endmodule

//--- rtl/lane_collector.sv
`include "pack_defines.svh"

module lane_collector (
  input  logic                   clk,
  input  logic                   rst,
  four_phase_if.receiver         lanes [`PACK_LANES],
  output logic                   out_req,
  input  logic                   out_ack,
  output pack_pkg::tagged_word_t out_data
);

  localparam int PTR_W = $clog2(`PACK_LANES);

  typedef enum logic [1:0] {
    WAIT_LANE,
    SEND,
    RELEASE,
    SEND_END
  } state_e;

  state_e                  state;
  logic [PTR_W-1:0]        ptr;
  logic [`PACK_LANES-1:0]  ack_q;
  logic [`PACK_LANES-1:0]  req_w;
  logic [`PACK_WORD_W-1:0] word_w [`PACK_LANES];
  logic                    last_w [`PACK_LANES];
  logic                    last_q; // Current word closes the stream

  genvar g;
  generate
    for (g = 0; g < `PACK_LANES; g++) begin : g_lane
      assign lanes[g].ack = ack_q[g];
      assign req_w[g]     = lanes[g].req;
      assign word_w[g]    = lanes[g].word;
      assign last_w[g]    = lanes[g].last;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= WAIT_LANE;
      ptr     <= '0;
      ack_q   <= '0;
      out_req <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      case (state)
        WAIT_LANE: begin
          if (req_w[ptr] && !out_ack) begin
            out_data.tag     <= pack_pkg::TAG_DATA;
            out_data.payload <= word_w[ptr];
            last_q           <= last_w[ptr];
            out_req          <= 1'b1;
            state            <= SEND;
          end
        end
        SEND: begin
          if (out_ack) begin
            out_req    <= 1'b0;
            ack_q[ptr] <= 1'b1; // Release the lane only once the packer has the word
            state      <= RELEASE;
          end
        end
        RELEASE: begin
          if (!req_w[ptr] && !out_ack) begin
            ack_q[ptr] <= 1'b0;
            if (ptr == PTR_W'(`PACK_LANES - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= ptr + 1'b1;
            end
            if (last_q) begin
              out_data.tag     <= pack_pkg::TAG_END;
              out_data.payload <= '0;
              out_req          <= 1'b1;
              state            <= SEND_END;
            end else begin
              state <= WAIT_LANE;
            end
          end
        end
        SEND_END: begin
          if (out_ack) begin
            out_req <= 1'b0;
            last_q  <= 1'b0;
            state   <= WAIT_LANE;
          end
        end
        default: state <= WAIT_LANE;
      endcase
    end
  end

endmodule

//--- rtl/word_lane.sv
`include "pack_defines.svh"

module word_lane (
  input  logic                    clk,
  input  logic                    rst,
  input  pack_pkg::op_e           op,
  input  logic [`PACK_WORD_W-1:0] key,
  four_phase_if.receiver          up,
  four_phase_if.sender            down
);

  typedef enum logic [1:0] {
    IDLE,
    HOLD,
    RELEASE
  } state_e;

  state_e                  state;
  logic                    up_ack_q;
  logic                    down_req_q;
  logic [`PACK_WORD_W-1:0] word_q;
  logic                    last_q;
  logic [`PACK_WORD_W-1:0] xform;

  always_comb begin
    case (op)
      pack_pkg::OP_INVERT:  xform = ~up.word;
      pack_pkg::OP_XOR_KEY: xform = up.word ^ key;
      pack_pkg::OP_SWAP:    xform = {<<8{up.word}};
      default:              xform = up.word;
    endcase
  end

  assign up.ack    = up_ack_q;
  assign down.req  = down_req_q;
  assign down.word = word_q;
  assign down.last = last_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      up_ack_q   <= 1'b0;
      down_req_q <= 1'b0;
    end else begin
      if (up_ack_q && !up.req) begin
        up_ack_q <= 1'b0; // Upstream release
      end
      case (state)
        IDLE: begin
          if (up.req && !up_ack_q) begin
            up_ack_q   <= 1'b1;
            down_req_q <= 1'b1;
            state      <= HOLD;
          end
        end
        HOLD: begin
          if (down.ack) begin
            down_req_q <= 1'b0;
            state      <= RELEASE;
          end
        end
        RELEASE: begin
          if (!down.ack && !up_ack_q) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && up.req && !up_ack_q) begin
      word_q <= xform;
      last_q <= up.last;
    end
  end

  // Collector must have closed the previous transfer
  a_no_req_on_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(down.req) |-> !down.ack);

endmodule

//--- rtl/word_dispatcher.sv
`include "pack_defines.svh"

module word_dispatcher (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic                    in_last,
  input  logic [`PACK_WORD_W-1:0] in_word,
  output logic                    in_ready,
  four_phase_if.sender            lanes [`PACK_LANES]
);

  localparam int PTR_W = $clog2(`PACK_LANES);

  logic [PTR_W-1:0]        ptr;
  logic                    run_q;                // Low until the first cycle after reset
  logic [`PACK_LANES-1:0]  req_q;
  logic [`PACK_LANES-1:0]  ack_w;
  logic [`PACK_WORD_W-1:0] word_q [`PACK_LANES];
  logic                    last_q [`PACK_LANES];
  logic                    take;

  genvar g;
  generate
    for (g = 0; g < `PACK_LANES; g++) begin : g_lane
      assign lanes[g].req  = req_q[g];
      assign lanes[g].word = word_q[g];
      assign lanes[g].last = last_q[g];
      assign ack_w[g]      = lanes[g].ack;

      // Lane holds on to the word while it has not acknowledged it
      a_stable: assert property (@(posedge clk) disable iff (rst)
        lanes[g].req && !lanes[g].ack |=> $stable(lanes[g].word) && $stable(lanes[g].last));
    end
  endgenerate

  // Target lane idle when neither half of the handshake is up
  assign in_ready = run_q && !req_q[ptr] && !ack_w[ptr];
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q <= 1'b0;
      ptr   <= '0;
      req_q <= '0;
    end else begin
      run_q <= 1'b1;
      for (int i = 0; i < `PACK_LANES; i++) begin
        if (req_q[i] && ack_w[i]) begin
          req_q[i] <= 1'b0; // Lane took the word
        end
      end
      if (take) begin
        req_q[ptr] <= 1'b1;
        if (ptr == PTR_W'(`PACK_LANES - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      word_q[ptr] <= in_word;
      last_q[ptr] <= in_last;
    end
  end

endmodule

//--- rtl/four_phase_if.sv
`include "pack_defines.svh"

interface four_phase_if;

  logic                    req;
  logic                    ack;
  logic [`PACK_WORD_W-1:0] word;
  logic                    last; // Final word of the stream

  modport sender (
    output req,
    output word,
    output last,
    input  ack
  );

  modport receiver (
    input  req,
    input  word,
    input  last,
    output ack
  );

endinterface

//--- rtl/pack_pkg.sv
`include "pack_defines.svh"

package pack_pkg;

  // Channel tag, one-hot like the line interface expects
  typedef enum logic [1:0] {
    TAG_DATA = 2'b01,
    TAG_END  = 2'b10
  } tag_e;

  typedef enum logic [1:0] {
    OP_PASS    = 2'b00, // Word unchanged
    OP_INVERT  = 2'b01, // Bitwise complement
    OP_XOR_KEY = 2'b10, // XOR with key
    OP_SWAP    = 2'b11  // Byte order reversed
  } op_e;

  // 34 bits, tag on top
  typedef struct packed {
    tag_e                    tag;
    logic [`PACK_WORD_W-1:0] payload;
  } tagged_word_t;

endpackage

//--- include/pack_defines.svh
`ifndef PACK_DEFINES_SVH
`define PACK_DEFINES_SVH

// Payload word carried on every channel
`define PACK_WORD_W 32

// One memory line and its word slots
`define PACK_LINE_W 512
`define PACK_WORDS_PER_LINE 16

// Slot counter, wide enough for 0..WORDS_PER_LINE-1
`define PACK_CNT_W 4

// Lane count, any value of 2 or more
`define PACK_LANES 4

`endif
